// ==== source/simd_seq_pkg.sv ====
`default_nettype none

package simd_seq_pkg;

	localparam int NS_ID_BITS = 3;
	localparam int NS_INDEX_BITS = 5;
	localparam int OPCODE_BITS = 4;
	localparam int FN_BITS = 4;
	localparam int INST_WIDTH = OPCODE_BITS + FN_BITS + 3 * (NS_ID_BITS + NS_INDEX_BITS);

	// Field positions, opcode at the top
	localparam int OPCODE_LSB = INST_WIDTH - OPCODE_BITS;
	localparam int FN_LSB = OPCODE_LSB - FN_BITS;
	localparam int DEST_ID_LSB = FN_LSB - NS_ID_BITS;
	localparam int DEST_INDEX_LSB = DEST_ID_LSB - NS_INDEX_BITS;
	localparam int SRC1_ID_LSB = DEST_INDEX_LSB - NS_ID_BITS;
	localparam int SRC1_INDEX_LSB = SRC1_ID_LSB - NS_INDEX_BITS;
	localparam int SRC2_ID_LSB = SRC1_INDEX_LSB - NS_ID_BITS;
	localparam int SRC2_INDEX_LSB = SRC2_ID_LSB - NS_INDEX_BITS;

	typedef enum logic [OPCODE_BITS-1:0] {
		OP_LD_ST = 4'd5,
		OP_LOOP = 4'd7,
		OP_PERMUTE = 4'd8,
		OP_GROUP = 4'd10
	} opcode_t;

	localparam logic [FN_BITS-1:0] FN_LOOP_COUNT = 4'd1;
	localparam logic [FN_BITS-1:0] FN_LOOP_START = 4'd2;
	localparam logic [FN_BITS-1:0] FN_LD_START = 4'd5;
	localparam logic [FN_BITS-1:0] FN_ST_START = 4'd13;
	localparam logic [FN_BITS-1:0] FN_PERM_START = 4'd3;
	localparam logic [1:0] FN_GROUP_END_HI = 2'd3; // Top two fn bits

	typedef enum logic [2:0] {
		CMD_ISSUE,
		CMD_LD,
		CMD_ST,
		CMD_PERM,
		CMD_LOOP_COUNT,
		CMD_LOOP_START,
		CMD_GROUP_END
	} cmd_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_GROUP_ADDR,
		S_FETCH,
		S_WAIT_INST,
		S_LD,
		S_ST,
		S_PERM
	} state_t;

endpackage

`default_nettype wire

// ==== source/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode #(
	parameter int LOOP_COUNT_W = 12
) (
	input  logic clk,
	input  logic reset,
	input  logic [simd_seq_pkg::INST_WIDTH-1:0] instruction_in,
	input  logic instruction_in_v,
	output simd_seq_pkg::cmd_t cmd,
	output logic cmd_v,
	output logic [LOOP_COUNT_W-1:0] loop_operand,
	output logic inst_v,
	output simd_seq_pkg::opcode_t opcode,
	output logic [simd_seq_pkg::FN_BITS-1:0] fn,
	output logic [simd_seq_pkg::NS_ID_BITS-1:0] dest_ns_id,
	output logic [simd_seq_pkg::NS_INDEX_BITS-1:0] dest_ns_index,
	output logic [simd_seq_pkg::NS_ID_BITS-1:0] src1_ns_id,
	output logic [simd_seq_pkg::NS_INDEX_BITS-1:0] src1_ns_index,
	output logic [simd_seq_pkg::NS_ID_BITS-1:0] src2_ns_id,
	output logic [simd_seq_pkg::NS_INDEX_BITS-1:0] src2_ns_index
);
	import simd_seq_pkg::*;

	opcode_t op_w;
	logic [FN_BITS-1:0] fn_w;
	logic issue_w;

	assign op_w = opcode_t'(instruction_in[OPCODE_LSB +: OPCODE_BITS]);
	assign fn_w = instruction_in[FN_LSB +: FN_BITS];
	assign cmd_v = instruction_in_v;
	assign loop_operand = instruction_in[LOOP_COUNT_W-1:0]; // Count or body length

	always_comb begin
		cmd = CMD_ISSUE;
		case (op_w)
		OP_LOOP: begin
			if (fn_w == FN_LOOP_COUNT) begin
				cmd = CMD_LOOP_COUNT;
			end else if (fn_w == FN_LOOP_START) begin
				cmd = CMD_LOOP_START;
			end
		end
		OP_LD_ST: begin
			if (fn_w == FN_LD_START) begin
				cmd = CMD_LD;
			end else if (fn_w == FN_ST_START) begin
				cmd = CMD_ST;
			end
		end
		OP_PERMUTE: begin
			if (fn_w == FN_PERM_START) begin
				cmd = CMD_PERM;
			end
		end
		OP_GROUP: begin
			if (fn_w[FN_BITS-1 -: 2] == FN_GROUP_END_HI) begin
				cmd = CMD_GROUP_END;
			end
		end
		default: begin
			cmd = CMD_ISSUE;
		end
		endcase
	end

	// Loop control and group end never leave the sequencer
	assign issue_w = instruction_in_v && (cmd inside {CMD_ISSUE, CMD_LD, CMD_ST, CMD_PERM});

	always_ff @(posedge clk) begin
		if (reset) begin
			inst_v <= 1'b0;
		end else begin
			inst_v <= issue_w;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_w) begin
			opcode <= op_w;
			fn <= fn_w;
			dest_ns_id <= instruction_in[DEST_ID_LSB +: NS_ID_BITS];
			dest_ns_index <= instruction_in[DEST_INDEX_LSB +: NS_INDEX_BITS];
			src1_ns_id <= instruction_in[SRC1_ID_LSB +: NS_ID_BITS];
			src1_ns_index <= instruction_in[SRC1_INDEX_LSB +: NS_INDEX_BITS];
			src2_ns_id <= instruction_in[SRC2_ID_LSB +: NS_ID_BITS];
			src2_ns_index <= instruction_in[SRC2_INDEX_LSB +: NS_INDEX_BITS];
		end
	end

endmodule

`default_nettype wire

// ==== source/seq_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_fsm #(
	parameter int GROUP_ID_W = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [GROUP_ID_W-1:0] group_id_s,
	input  logic group_buf_rd_v,
	input  simd_seq_pkg::cmd_t cmd,
	input  logic cmd_v,
	input  logic ld_done,
	input  logic st_done,
	input  logic perm_done,
	output logic ready,
	output logic done,
	output logic stall,
	output logic in_ld_st,
	output logic in_shuffle,
	output logic group_buf_rd_req,
	output logic [GROUP_ID_W-1:0] group_buf_rd_addr,
	output logic load_start_addr,
	output logic rd_go,
	output logic advance
);
	import simd_seq_pkg::*;

	state_t state_q;
	state_t state_d;
	logic start_ok;
	logic group_end;
	logic finish_inst; // Current instruction is complete

	assign start_ok = ready && start;
	assign group_end = (state_q == S_WAIT_INST) && cmd_v && (cmd == CMD_GROUP_END);

	always_comb begin
		state_d = state_q;
		finish_inst = 1'b0;
		case (state_q)
		S_IDLE: begin
			if (start) begin
				state_d = S_GROUP_ADDR;
			end
		end
		S_GROUP_ADDR: begin
			if (group_buf_rd_v) begin
				state_d = S_FETCH;
			end
		end
		S_FETCH: begin
			state_d = S_WAIT_INST;
		end
		S_WAIT_INST: begin
			if (cmd_v) begin
				case (cmd)
				CMD_GROUP_END: state_d = S_IDLE;
				CMD_LD: state_d = S_LD;
				CMD_ST: state_d = S_ST;
				CMD_PERM: state_d = S_PERM;
				default: begin // Issue and loop control
					state_d = S_FETCH;
					finish_inst = 1'b1;
				end
				endcase
			end
		end
		S_LD: begin
			if (ld_done) begin
				state_d = S_FETCH;
				finish_inst = 1'b1;
			end
		end
		S_ST: begin
			if (st_done) begin
				state_d = S_FETCH;
				finish_inst = 1'b1;
			end
		end
		S_PERM: begin
			if (perm_done) begin
				state_d = S_FETCH;
				finish_inst = 1'b1;
			end
		end
		default: begin
			state_d = S_IDLE;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= S_IDLE;
			advance <= 1'b0;
			done <= 1'b0;
			group_buf_rd_req <= 1'b0;
		end else begin
			state_q <= state_d;
			advance <= finish_inst;
			done <= group_end;
			group_buf_rd_req <= start_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok) begin
			group_buf_rd_addr <= group_id_s;
		end
	end

	assign ready = (state_q == S_IDLE);
	assign in_ld_st = (state_q == S_LD) || (state_q == S_ST);
	assign in_shuffle = (state_q == S_PERM);
	assign stall = in_ld_st || in_shuffle;

	// Start address is only valid alongside its valid strobe
	assign load_start_addr = (state_q == S_GROUP_ADDR) && group_buf_rd_v;
	assign rd_go = (state_q == S_FETCH);

endmodule

`default_nettype wire

// ==== source/loop_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module loop_counter #(
	parameter int IMEM_ADDR_WIDTH = 10,
	parameter int LOOP_COUNT_W = 12
) (
	input  logic clk,
	input  logic reset,
	input  simd_seq_pkg::cmd_t cmd,
	input  logic cmd_v,
	input  logic [LOOP_COUNT_W-1:0] loop_operand,
	input  logic advance,
	input  logic [IMEM_ADDR_WIDTH-1:0] cur_addr,
	output logic jump_back,
	output logic in_loop,
	output logic [IMEM_ADDR_WIDTH-1:0] loop_start_addr
);
	import simd_seq_pkg::*;

	logic [LOOP_COUNT_W-1:0] num_passes; // N
	logic [LOOP_COUNT_W-1:0] body_len;   // L
	logic [LOOP_COUNT_W-1:0] body_pos;
	logic [LOOP_COUNT_W-1:0] pass_cnt;
	logic armed;
	logic body_last;
	logic last_pass;

	assign body_last = (body_pos == body_len - LOOP_COUNT_W'(1));
	assign last_pass = (pass_cnt == num_passes - LOOP_COUNT_W'(1));
	assign jump_back = in_loop && body_last && !last_pass;

	always_ff @(posedge clk) begin
		if (cmd_v && (cmd == CMD_LOOP_COUNT)) begin
			num_passes <= loop_operand;
		end
		if (cmd_v && (cmd == CMD_LOOP_START)) begin
			body_len <= loop_operand;
			loop_start_addr <= cur_addr + IMEM_ADDR_WIDTH'(1); // Body follows the loop start
		end
	end

	// The loop-start instruction's own advance opens the loop
	always_ff @(posedge clk) begin
		if (reset) begin
			armed <= 1'b0;
			in_loop <= 1'b0;
			body_pos <= '0;
			pass_cnt <= '0;
		end else if (cmd_v && (cmd == CMD_LOOP_START)) begin
			armed <= 1'b1;
		end else if (advance && armed) begin
			armed <= 1'b0;
			in_loop <= 1'b1;
			body_pos <= '0;
			pass_cnt <= '0;
		end else if (advance && in_loop) begin
			if (body_last) begin
				body_pos <= '0;
				if (last_pass) begin
					in_loop <= 1'b0;
				end else begin
					pass_cnt <= pass_cnt + LOOP_COUNT_W'(1);
				end
			end else begin
				body_pos <= body_pos + LOOP_COUNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/fetch_pointer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pointer #(
	parameter int IMEM_ADDR_WIDTH = 10
) (
	input  logic clk,
	input  logic reset,
	input  logic load_start_addr,
	input  logic [IMEM_ADDR_WIDTH-1:0] start_addr,
	input  logic advance,
	input  logic jump_back,
	input  logic [IMEM_ADDR_WIDTH-1:0] loop_start_addr,
	input  logic rd_go,
	output logic [IMEM_ADDR_WIDTH-1:0] imem_rd_address,
	output logic imem_rd_req
);

	logic [IMEM_ADDR_WIDTH-1:0] next_addr;

	// Step to the next instruction or back to the top of the loop body
	assign next_addr = jump_back ? loop_start_addr : imem_rd_address + IMEM_ADDR_WIDTH'(1);

	always_ff @(posedge clk) begin
		if (reset) begin
			imem_rd_address <= '0;
		end else if (load_start_addr) begin
			imem_rd_address <= start_addr; // Group start from the group buffer
		end else if (advance) begin
			imem_rd_address <= next_addr;
		end
	end

	// One read per rd_go, issued at the updated address
	always_ff @(posedge clk) begin
		if (reset) begin
			imem_rd_req <= 1'b0;
		end else begin
			imem_rd_req <= rd_go;
		end
	end

endmodule

`default_nettype wire

// ==== source/simd_seq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_seq_top #(
	parameter int IMEM_ADDR_WIDTH = 10,
	parameter int GROUP_ID_W = 4,
	parameter int LOOP_COUNT_W = 12
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [GROUP_ID_W-1:0] group_id_s,
	input  logic [IMEM_ADDR_WIDTH-1:0] group_buf_rd_data,
	input  logic group_buf_rd_v,
	input  logic [simd_seq_pkg::INST_WIDTH-1:0] instruction_in,
	input  logic instruction_in_v,
	input  logic ld_done,
	input  logic st_done,
	input  logic perm_done,
	output logic ready,
	output logic done,
	output logic stall,
	output logic in_ld_st,
	output logic in_shuffle,
	output logic group_buf_rd_req,
	output logic [GROUP_ID_W-1:0] group_buf_rd_addr,
	output logic imem_rd_req,
	output logic [IMEM_ADDR_WIDTH-1:0] imem_rd_address,
	output logic inst_v,
	output simd_seq_pkg::opcode_t opcode,
	output logic [simd_seq_pkg::FN_BITS-1:0] fn,
	output logic [simd_seq_pkg::NS_ID_BITS-1:0] dest_ns_id,
	output logic [simd_seq_pkg::NS_INDEX_BITS-1:0] dest_ns_index,
	output logic [simd_seq_pkg::NS_ID_BITS-1:0] src1_ns_id,
	output logic [simd_seq_pkg::NS_INDEX_BITS-1:0] src1_ns_index,
	output logic [simd_seq_pkg::NS_ID_BITS-1:0] src2_ns_id,
	output logic [simd_seq_pkg::NS_INDEX_BITS-1:0] src2_ns_index
);
	import simd_seq_pkg::*;

	cmd_t cmd;
	logic cmd_v;
	logic [LOOP_COUNT_W-1:0] loop_operand;
	logic advance;
	logic load_start_addr;
	logic rd_go;
	logic jump_back;
	logic [IMEM_ADDR_WIDTH-1:0] loop_start_addr;

	inst_decode #(
		.LOOP_COUNT_W(LOOP_COUNT_W)
	) i_inst_decode (
		.clk(clk),
		.reset(reset),
		.instruction_in(instruction_in),
		.instruction_in_v(instruction_in_v),
		.cmd(cmd),
		.cmd_v(cmd_v),
		.loop_operand(loop_operand),
		.inst_v(inst_v),
		.opcode(opcode),
		.fn(fn),
		.dest_ns_id(dest_ns_id),
		.dest_ns_index(dest_ns_index),
		.src1_ns_id(src1_ns_id),
		.src1_ns_index(src1_ns_index),
		.src2_ns_id(src2_ns_id),
		.src2_ns_index(src2_ns_index)
	);

	seq_fsm #(
		.GROUP_ID_W(GROUP_ID_W)
	) i_seq_fsm (
		.clk(clk),
		.reset(reset),
		.start(start),
		.group_id_s(group_id_s),
		.group_buf_rd_v(group_buf_rd_v),
		.cmd(cmd),
		.cmd_v(cmd_v),
		.ld_done(ld_done),
		.st_done(st_done),
		.perm_done(perm_done),
		.ready(ready),
		.done(done),
		.stall(stall),
		.in_ld_st(in_ld_st),
		.in_shuffle(in_shuffle),
		.group_buf_rd_req(group_buf_rd_req),
		.group_buf_rd_addr(group_buf_rd_addr),
		.load_start_addr(load_start_addr),
		.rd_go(rd_go),
		.advance(advance)
	);

	loop_counter #(
		.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH),
		.LOOP_COUNT_W(LOOP_COUNT_W)
	) i_loop_counter (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.cmd_v(cmd_v),
		.loop_operand(loop_operand),
		.advance(advance),
		.cur_addr(imem_rd_address),
		.jump_back(jump_back),
		.in_loop(), // Loop status stays internal
		.loop_start_addr(loop_start_addr)
	);

	fetch_pointer #(
		.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)
	) i_fetch_pointer (
		.clk(clk),
		.reset(reset),
		.load_start_addr(load_start_addr),
		.start_addr(group_buf_rd_data),
		.advance(advance),
		.jump_back(jump_back),
		.loop_start_addr(loop_start_addr),
		.rd_go(rd_go),
		.imem_rd_address(imem_rd_address),
		.imem_rd_req(imem_rd_req)
	);

endmodule

`default_nettype wire

// ==== tests/seq_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_checker (
	input  logic clk,
	input  logic reset,
	input  logic exp_push,
	input  logic [31:0] exp_word,
	input  logic [3:0] exp_gid,
	input  logic ready,
	input  logic done,
	input  logic stall,
	input  logic in_ld_st,
	input  logic in_shuffle,
	input  logic ld_done,
	input  logic st_done,
	input  logic perm_done,
	input  logic group_buf_rd_req,
	input  logic [3:0] group_buf_rd_addr,
	input  logic imem_rd_req,
	input  logic inst_v,
	input  simd_seq_pkg::opcode_t opcode,
	input  logic [3:0] fn,
	input  logic [2:0] dest_ns_id,
	input  logic [4:0] dest_ns_index,
	input  logic [2:0] src1_ns_id,
	input  logic [4:0] src1_ns_index,
	input  logic [2:0] src2_ns_id,
	input  logic [4:0] src2_ns_index,
	output int error_count,
	output int done_count,
	output int issue_count
);
	import simd_seq_pkg::*;

	logic [31:0] exp_q [$];
	logic [31:0] w;
	int wait_kind = 0; // 0 none, 1 load, 2 store, 3 permute
	bit released = 1'b0;
	logic is_ld_st;
	logic is_perm;
	int errs = 0;
	int dones = 0;
	int issues = 0;

	assign error_count = errs;
	assign done_count = dones;
	assign issue_count = issues;

	task automatic check_field(input string name, input int got, input int want);
		if (got != want) begin
			$display("ERROR %0t %s got %0h expected %0h", $time, name, got, want);
			errs++;
		end
	endtask

	always @(posedge clk) begin
		if (exp_push) begin
			exp_q.push_back(exp_word);
		end
		// Matching done taken by the DUT on this edge
		if ((wait_kind == 1 && ld_done) || (wait_kind == 2 && st_done)
			|| (wait_kind == 3 && perm_done)) begin
			released = 1'b1;
		end
	end

	// Everything is sampled mid-cycle, away from the DUT's clock edge
	always @(negedge clk) begin
		if (reset) begin
			check_field("ready", int'(ready), 1);
			check_field("inst_v", int'(inst_v), 0);
			check_field("done", int'(done), 0);
			check_field("stall", int'(stall), 0);
			check_field("in_ld_st", int'(in_ld_st), 0);
			check_field("in_shuffle", int'(in_shuffle), 0);
			check_field("imem_rd_req", int'(imem_rd_req), 0);
			check_field("group_buf_rd_req", int'(group_buf_rd_req), 0);
			wait_kind = 0;
			released = 1'b0;
		end else begin
			if (wait_kind != 0) begin
				if (released) begin
					check_field("stall", int'(stall), 0); // Falls right after the done
					wait_kind = 0;
					released = 1'b0;
				end else begin
					check_field("stall", int'(stall), 1);
					check_field("in_ld_st", int'(in_ld_st), int'(wait_kind != 3));
					check_field("in_shuffle", int'(in_shuffle), int'(wait_kind == 3));
				end
			end
			if (inst_v) begin
				if (wait_kind != 0) begin
					$display("ERROR %0t instruction issued before the matching done pulse",
						$time);
					errs++;
					wait_kind = 0;
					released = 1'b0;
				end
				if (exp_q.size() == 0) begin
					$display("ERROR %0t instruction issued that the program does not hold",
						$time);
					errs++;
				end else begin
					w = exp_q.pop_front();
					is_ld_st = (w[31:28] == OP_LD_ST)
						&& (w[27:24] == FN_LD_START || w[27:24] == FN_ST_START);
					is_perm = (w[31:28] == OP_PERMUTE) && (w[27:24] == FN_PERM_START);
					check_field("opcode", int'(opcode), int'(w[31:28]));
					check_field("fn", int'(fn), int'(w[27:24]));
					check_field("dest_ns_id", int'(dest_ns_id), int'(w[23:21]));
					check_field("dest_ns_index", int'(dest_ns_index), int'(w[20:16]));
					check_field("src1_ns_id", int'(src1_ns_id), int'(w[15:13]));
					check_field("src1_ns_index", int'(src1_ns_index), int'(w[12:8]));
					check_field("src2_ns_id", int'(src2_ns_id), int'(w[7:5]));
					check_field("src2_ns_index", int'(src2_ns_index), int'(w[4:0]));
					check_field("stall", int'(stall), int'(is_ld_st || is_perm));
					check_field("in_ld_st", int'(in_ld_st), int'(is_ld_st));
					check_field("in_shuffle", int'(in_shuffle), int'(is_perm));
					if (is_perm) begin
						wait_kind = 3;
					end else if (is_ld_st) begin
						wait_kind = (w[27:24] == FN_ST_START) ? 2 : 1;
					end
					issues++;
				end
			end
			if (group_buf_rd_req) begin
				check_field("group_buf_rd_addr", int'(group_buf_rd_addr), int'(exp_gid));
			end
			if (done) begin
				dones++;
				check_field("ready", int'(ready), 1);
				if (exp_q.size() != 0) begin
					$display("ERROR %0t group ended with %0d expected issues missing",
						$time, exp_q.size());
					errs++;
					exp_q.delete();
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_simd_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_simd_seq;
	import simd_seq_pkg::*;

	localparam int RUNS = 8;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic start = 1'b0;
	logic [3:0] group_id_s = '0;
	logic [9:0] group_buf_rd_data = '0;
	logic group_buf_rd_v = 1'b0;
	logic [31:0] instruction_in = '0;
	logic instruction_in_v = 1'b0;
	logic ld_done = 1'b0;
	logic st_done = 1'b0;
	logic perm_done = 1'b0;

	logic ready, done, stall, in_ld_st, in_shuffle;
	logic group_buf_rd_req, imem_rd_req, inst_v;
	logic [3:0] group_buf_rd_addr;
	logic [9:0] imem_rd_address;
	opcode_t opcode;
	logic [3:0] fn;
	logic [2:0] dest_ns_id, src1_ns_id, src2_ns_id;
	logic [4:0] dest_ns_index, src1_ns_index, src2_ns_index;

	logic exp_push = 1'b0;
	logic [31:0] exp_word = '0;
	logic [3:0] exp_gid = '0;
	int error_count, done_count, issue_count;

	integer seed = 32'h78a0;
	logic [31:0] imem [0:1023];
	logic [9:0] gbuf [0:15];
	bit timed_out = 1'b0;
	int tb_errors = 0;
	int runs_done = 0;

	// Responder state
	bit mem_pending = 1'b0;
	int mem_delay = 0;
	logic [9:0] mem_addr = '0;
	bit gb_pending = 1'b0;
	int gb_delay = 0;
	bit done_pending = 1'b0;
	int done_delay = 0;
	int done_kind = 0; // 0 ld, 1 st, 2 perm
	bit stall_seen = 1'b0;

	simd_seq_top #(
		.IMEM_ADDR_WIDTH(10),
		.GROUP_ID_W(4),
		.LOOP_COUNT_W(12)
	) i_simd_seq_top (
		.clk(clk), .reset(reset), .start(start), .group_id_s(group_id_s),
		.group_buf_rd_data(group_buf_rd_data), .group_buf_rd_v(group_buf_rd_v),
		.instruction_in(instruction_in), .instruction_in_v(instruction_in_v),
		.ld_done(ld_done), .st_done(st_done), .perm_done(perm_done),
		.ready(ready), .done(done), .stall(stall), .in_ld_st(in_ld_st),
		.in_shuffle(in_shuffle), .group_buf_rd_req(group_buf_rd_req),
		.group_buf_rd_addr(group_buf_rd_addr), .imem_rd_req(imem_rd_req),
		.imem_rd_address(imem_rd_address), .inst_v(inst_v), .opcode(opcode), .fn(fn),
		.dest_ns_id(dest_ns_id), .dest_ns_index(dest_ns_index),
		.src1_ns_id(src1_ns_id), .src1_ns_index(src1_ns_index),
		.src2_ns_id(src2_ns_id), .src2_ns_index(src2_ns_index)
	);

	seq_checker i_checker (
		.clk(clk), .reset(reset), .exp_push(exp_push), .exp_word(exp_word),
		.exp_gid(exp_gid), .ready(ready), .done(done), .stall(stall),
		.in_ld_st(in_ld_st), .in_shuffle(in_shuffle),
		.ld_done(ld_done), .st_done(st_done), .perm_done(perm_done),
		.group_buf_rd_req(group_buf_rd_req), .group_buf_rd_addr(group_buf_rd_addr),
		.imem_rd_req(imem_rd_req), .inst_v(inst_v), .opcode(opcode), .fn(fn),
		.dest_ns_id(dest_ns_id), .dest_ns_index(dest_ns_index),
		.src1_ns_id(src1_ns_id), .src1_ns_index(src1_ns_index),
		.src2_ns_id(src2_ns_id), .src2_ns_index(src2_ns_index),
		.error_count(error_count), .done_count(done_count), .issue_count(issue_count)
	);

	initial begin
		forever begin
			#20 clk = ~clk;
		end
	end

	function automatic int rnd(input int range);
		int r;
		r = $random(seed);
		return int'($unsigned(r) % range);
	endfunction

	// Loop control and group end stay inside the sequencer
	function automatic bit is_issued(input logic [31:0] w);
		if (w[31:28] == OP_LOOP && (w[27:24] == FN_LOOP_COUNT || w[27:24] == FN_LOOP_START)) begin
			return 1'b0;
		end
		if (w[31:28] == OP_GROUP && w[27:26] == FN_GROUP_END_HI) begin
			return 1'b0;
		end
		return 1'b1;
	endfunction

	function automatic logic [31:0] random_inst();
		int r;
		int op;
		r = rnd(10);
		if (r == 0) begin
			return {OP_LD_ST, FN_LD_START, 24'(rnd(1 << 24))};
		end else if (r == 1) begin
			return {OP_LD_ST, FN_ST_START, 24'(rnd(1 << 24))};
		end else if (r == 2) begin
			return {OP_PERMUTE, FN_PERM_START, 24'(rnd(1 << 24))};
		end
		op = rnd(16);
		if (op == 7 || op == 10) begin
			op = op + 1; // Keep clear of loop and group opcodes
		end
		return {4'(op), 4'(rnd(16)), 24'(rnd(1 << 24))};
	endfunction

	task automatic push_expected(input logic [31:0] w);
		exp_word = w;
		exp_push = 1'b1;
		@(negedge clk);
		exp_push = 1'b0;
	endtask

	task automatic build_program(input int id);
		logic [31:0] prog [0:63];
		int n, lc, ll, lp, i, j, k, passes, base;
		base = id * 64;
		n = 10 + rnd(21);
		for (i = 0; i < n - 1; i++) begin
			prog[i] = random_inst();
		end
		prog[n-1] = {OP_GROUP, FN_GROUP_END_HI, 2'(rnd(4)), 24'(rnd(1 << 24))};
		if (rnd(2) == 1) begin
			lc = 1 + rnd(4);
			ll = 1 + rnd(6);
			lp = rnd(n - 2 - ll);
			prog[lp] = {OP_LOOP, FN_LOOP_COUNT, 12'(rnd(4096)), 12'(lc)};
			prog[lp+1] = {OP_LOOP, FN_LOOP_START, 12'(rnd(4096)), 12'(ll)};
		end
		for (i = 0; i < n; i++) begin
			imem[base+i] = prog[i];
		end
		gbuf[id] = 10'(base);
		// Unroll into the expected issue order
		passes = 1;
		i = 0;
		while (i < n) begin
			if (prog[i][31:28] == OP_LOOP && prog[i][27:24] == FN_LOOP_COUNT) begin
				passes = int'(prog[i][11:0]);
				i++;
			end else if (prog[i][31:28] == OP_LOOP && prog[i][27:24] == FN_LOOP_START) begin
				ll = int'(prog[i][11:0]);
				for (k = 0; k < passes; k++) begin
					for (j = 1; j <= ll; j++) begin
						if (is_issued(prog[i+j])) begin
							push_expected(prog[i+j]);
						end
					end
				end
				i = i + ll + 1;
			end else if (!is_issued(prog[i])) begin
				i = n;
			end else begin
				push_expected(prog[i]);
				i++;
			end
		end
	endtask

	task automatic wait_for_ready();
		int cycles;
		cycles = 0;
		while (!ready && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (!ready) begin
			$display("Timeout: sequencer never became ready for group %0d", exp_gid);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < 20000) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("Timeout: no done pulse for group %0d", exp_gid);
			timed_out = 1'b1;
		end
	endtask

	// Instruction memory, answers 1 to 3 cycles after the request
	always @(negedge clk) begin
		instruction_in_v = 1'b0;
		if (imem_rd_req) begin
			mem_pending = 1'b1;
			mem_addr = imem_rd_address;
			mem_delay = 1 + rnd(3);
		end
		if (mem_pending) begin
			mem_delay = mem_delay - 1;
			if (mem_delay == 0) begin
				instruction_in = imem[mem_addr];
				instruction_in_v = 1'b1;
				mem_pending = 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		group_buf_rd_v = 1'b0;
		if (group_buf_rd_req) begin
			gb_pending = 1'b1;
			gb_delay = 1 + rnd(4);
		end
		if (gb_pending) begin
			gb_delay = gb_delay - 1;
			if (gb_delay == 0) begin
				group_buf_rd_data = gbuf[group_buf_rd_addr];
				group_buf_rd_v = 1'b1;
				gb_pending = 1'b0;
			end
		end
	end

	// Done pulses; a wrong done comes first now and then and must be ignored
	always @(negedge clk) begin
		ld_done = 1'b0;
		st_done = 1'b0;
		perm_done = 1'b0;
		if (stall && !stall_seen) begin
			done_pending = 1'b1;
			done_delay = 2 + rnd(7);
			done_kind = in_shuffle ? 2 : ((fn == FN_ST_START) ? 1 : 0);
		end
		stall_seen = stall;
		if (done_pending) begin
			done_delay = done_delay - 1;
			if (done_delay == 0) begin
				ld_done = (done_kind == 0);
				st_done = (done_kind == 1);
				perm_done = (done_kind == 2);
				done_pending = 1'b0;
			end else if (done_delay == 1 && rnd(2) == 1) begin
				ld_done = (done_kind != 0);
				st_done = (done_kind == 0);
			end
		end
	end

	initial begin
		int a, run, id, prev_id, total;
		for (a = 0; a < 1024; a++) begin
			imem[a] = {OP_GROUP, 4'hc, 14'(a * 7), 10'(a)};
		end
		for (a = 0; a < 16; a++) begin
			gbuf[a] = 10'(a * 64);
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;
		prev_id = -1;
		for (run = 0; run < RUNS && !timed_out; run++) begin
			id = rnd(16);
			if (id == prev_id) begin
				id = (id + 1) % 16;
			end
			prev_id = id;
			exp_gid = 4'(id);
			build_program(id);
			wait_for_ready();
			if (!timed_out) begin
				start = 1'b1;
				group_id_s = 4'(id);
				@(negedge clk);
				start = 1'b0;
				wait_for_done();
				@(negedge clk);
				runs_done++;
			end
		end
		repeat (4) @(negedge clk);
		if (done_count != runs_done) begin
			$display("Saw %0d done pulses for %0d finished programs", done_count, runs_done);
			tb_errors++;
		end
		total = error_count + tb_errors + int'(timed_out);
		$display("Runs %0d, issues %0d, checker errors %0d, testbench errors %0d",
			runs_done, issue_count, error_count, tb_errors + int'(timed_out));
		if (total == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/simd_seq_pkg.sv
source/inst_decode.sv
source/seq_fsm.sv
source/loop_counter.sv
source/fetch_pointer.sv
source/simd_seq_top.sv
tests/seq_checker.sv
tests/tb_simd_seq.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	-f verilog.f \
	--top-module tb_simd_seq \
	--Mdir obj_dir \
	-o tb_simd_seq

./obj_dir/tb_simd_seq | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
